// ==== flist.f ====
+incdir+source
source/ppu_bus_pkg.sv
source/ppu_mem_pkg.sv
source/ppu_reg_decode.sv
source/vram_port.sv
source/cgram_port.sv
source/m7_multiplier.sv
source/hv_counter_latch.sv
source/read_mux.sv
source/ppu_cpu_port.sv
sim/ppu_cpu_port_checker.sv
sim/ppu_cpu_port_tb.sv

// ==== sim/ppu_cpu_port_tb.sv ====
// --------------------
// Testbench for the PPU CPU port: bus tasks,
// VRAM, palette, product and beam models, report
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_cpu_port_tb;
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    localparam int N_TESTS = 6;
    localparam longint TIMEOUT_NS = N_TESTS * 400 * 3 * 40;

    logic      clk;
    logic      reset;
    logic      cpu_en;
    b_op_t     b_op;
    bus_byte_t wdata;
    bus_byte_t rdata;
    hv_count_t h_ctr;
    hv_count_t v_ctr;

    bus_byte_t last_rdata;
    hv_count_t last_h;
    hv_count_t last_v;
    hv_count_t last_beam_h;
    hv_count_t last_beam_v;
    int        errors;
    int        checks;
    int        tests;
    int        err_base;

    // Beam position model
    hv_count_t beam_h;
    hv_count_t beam_v;

    // VRAM model with the address register and prefetch
    vram_word_t vram_model [0:`PPU_VRAM_WORDS-1];
    vram_addr_t m_addr;
    vram_word_t m_pf;
    vram_addr_t m_step;
    int         m_remap;
    logic       m_inc_hi;
    color_t     pal_model [0:`PPU_CGRAM_ENTRIES-1];

    ppu_cpu_port i_ppu_cpu_port (
        .clk, .reset, .cpu_en, .b_op, .wdata, .rdata, .h_ctr, .v_ctr
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog timeout: tests still running after %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $finish;
    end

    // Dots wrap at the end of the line, lines at the end of the frame
    always @(posedge clk) begin
        if (reset) begin
            beam_h <= '0;
            beam_v <= '0;
        end else begin
            beam_h <= (beam_h == `PPU_H_DOTS - 1) ? 9'd0 : beam_h + 9'd1;
            if (beam_h == `PPU_H_DOTS - 1) begin
                beam_v <= (beam_v == `PPU_V_LINES - 1) ? 9'd0 : beam_v + 9'd1;
            end
        end
    end

    // --------------------
    // Bus access and checking

    // One operation, rdata sampled mid-cycle, then two idle cycles
    task automatic bus_cycle(input b_op_t op, input bus_byte_t data);
        cpu_en <= 1'b1;
        b_op <= op;
        wdata <= data;
        @(negedge clk);
        last_rdata = rdata;
        last_h = h_ctr;
        last_v = v_ctr;
        last_beam_h = beam_h;
        last_beam_v = beam_v;
        @(posedge clk);
        cpu_en <= 1'b0;
        b_op <= B_NOP;
        wdata <= '0;
        repeat (2) @(posedge clk);
    endtask

    task automatic check_rdata(input string what, input bus_byte_t exp);
        checks++;
        assert (last_rdata === exp) else begin
            errors++;
            $display("Error at %0t ns: rdata (%s) expected %02h, got %02h",
                     $time, what, exp, last_rdata);
        end
    endtask

    task automatic check_count(input string name, input hv_count_t exp, input hv_count_t got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, got);
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%s: %0d errors", name, errors - err_base);
        err_base = errors;
    endtask

    // Rotate the low 8+mode bits left by 3
    function automatic vram_addr_t remap_addr(input vram_addr_t a, input int mode);
        int         w;
        vram_addr_t mask;
        vram_addr_t low;
        if (mode == 0) begin
            return a;
        end
        w = 8 + mode;
        mask = (15'd1 << w) - 15'd1;
        low = a & mask;
        return (a & ~mask) | (((low << 3) | (low >> (w - 3))) & mask);
    endfunction

    // --------------------
    // VRAM model steps

    task automatic set_vmain(input bus_byte_t mode);
        bus_cycle(B_VMAIN, mode);
        m_inc_hi = mode[7];
        m_remap = mode[3:2];
        m_step = (mode[1:0] == 2'd0) ? 15'd1 : (mode[1:0] == 2'd1) ? 15'd32 : 15'd128;
    endtask

    task automatic set_vaddr(input vram_addr_t a);
        bus_cycle(B_VMADDL, a[7:0]);
        bus_cycle(B_VMADDH, {1'b0, a[14:8]});
        m_addr = a;
        m_pf = vram_model[remap_addr(m_addr, m_remap)];
    endtask

    task automatic vram_byte_write(input logic hi, input bus_byte_t d);
        vram_addr_t idx;
        bus_cycle(hi ? B_VMDATAH : B_VMDATAL, d);
        idx = remap_addr(m_addr, m_remap);
        if (hi) vram_model[idx][15:8] = d;
        else vram_model[idx][7:0] = d;
        if (hi == m_inc_hi) begin
            m_addr = m_addr + m_step;
            m_pf = vram_model[remap_addr(m_addr, m_remap)];
        end
    endtask

    task automatic vram_write_word(input vram_word_t w);
        // The byte that triggers the increment goes last
        vram_byte_write(~m_inc_hi, m_inc_hi ? w[7:0] : w[15:8]);
        vram_byte_write(m_inc_hi, m_inc_hi ? w[15:8] : w[7:0]);
    endtask

    task automatic vram_read_pair();
        vram_word_t exp;
        exp = m_pf;
        bus_cycle(m_inc_hi ? B_RDVRAML : B_RDVRAMH, 8'h0);
        check_rdata("VRAM first byte", m_inc_hi ? exp[7:0] : exp[15:8]);
        bus_cycle(m_inc_hi ? B_RDVRAMH : B_RDVRAML, 8'h0);
        check_rdata("VRAM second byte", m_inc_hi ? exp[15:8] : exp[7:0]);
        m_pf = vram_model[remap_addr(m_addr, m_remap)];
        m_addr = m_addr + m_step;
    endtask

    // --------------------
    // Tests

    task automatic check_reset_values();
        bus_cycle(B_MPYL, 8'h0);
        check_rdata("MPYL", 8'h00);
        bus_cycle(B_MPYM, 8'h0);
        check_rdata("MPYM", 8'h00);
        bus_cycle(B_MPYH, 8'h0);
        check_rdata("MPYH", 8'h00);
        bus_cycle(B_STAT78, 8'h0);
        check_rdata("STAT78", 8'(`PPU_VERSION));
        finish_test("reset values");
    endtask

    task automatic vram_round_trip();
        vram_addr_t base;
        base = 15'($urandom);
        set_vmain(8'h80);
        set_vaddr(base);
        repeat (8) vram_write_word(16'($urandom));
        set_vaddr(base);
        repeat (8) vram_read_pair();
        finish_test("VRAM step 1");
    endtask

    task automatic vram_step_remap();
        vram_addr_t base;
        vram_addr_t loc;
        vram_addr_t step;
        int         map_mode;
        bus_byte_t  mode;
        for (int i = 0; i < 6; i++) begin
            mode = {(i < 3) ? 1'b1 : 1'b0, 3'b000, 2'(i / 2 + 1), (i % 2) ? 2'd2 : 2'd1};
            base = 15'($urandom);
            set_vmain(mode);
            set_vaddr(base);
            repeat (4) vram_write_word(16'($urandom));
            set_vaddr(base);
            repeat (5) vram_read_pair();
            step = m_step;
            map_mode = m_remap;
            // Plain addressing finds each word where step and rotation put it
            set_vmain(mode & 8'h80);
            for (int k = 0; k < 4; k++) begin
                loc = remap_addr(base + 15'(k) * step, map_mode);
                set_vaddr(loc);
                vram_read_pair();
            end
        end
        finish_test("VRAM steps and remap");
    endtask

    task automatic palette_round_trip();
        cgram_addr_t base;
        bus_byte_t   lo;
        bus_byte_t   hi;
        base = 8'($urandom);
        bus_cycle(B_CGADD, base);
        for (int k = 0; k < 8; k++) begin
            lo = 8'($urandom);
            hi = 8'($urandom);
            bus_cycle(B_CGDATA, lo);
            bus_cycle(B_CGDATA, hi);
            pal_model[8'(base + k)] = {hi[6:0], lo};
        end
        bus_cycle(B_CGADD, base);
        for (int k = 0; k < 8; k++) begin
            bus_cycle(B_RDCGRAM, 8'h0);
            check_rdata("CGRAM low", pal_model[8'(base + k)][7:0]);
            bus_cycle(B_RDCGRAM, 8'h0);
            check_rdata("CGRAM high", {1'b0, pal_model[8'(base + k)][14:8]});
        end
        finish_test("palette");
    endtask

    task automatic multiplier_products();
        m7_operand_t ma;
        bus_byte_t   mb;
        bus_byte_t   old;
        bus_byte_t   d;
        b_op_t       op;
        int          prod;
        ma = '0;
        mb = '0;
        old = '0;
        for (int i = 0; i < 20; i++) begin
            for (int j = 0; j < 3; j++) begin
                op = ($urandom % 3 == 0) ? B_M7B : B_M7A;
                d = 8'($urandom);
                bus_cycle(op, d);
                if (op == B_M7A) ma = {d, old};
                else mb = d;
                old = d;
            end
            prod = int'(signed'(ma)) * int'(signed'(mb));
            bus_cycle(B_MPYL, 8'h0);
            check_rdata("MPYL", prod[7:0]);
            bus_cycle(B_MPYM, 8'h0);
            check_rdata("MPYM", prod[15:8]);
            bus_cycle(B_MPYH, 8'h0);
            check_rdata("MPYH", prod[23:16]);
        end
        finish_test("multiplier");
    endtask

    task automatic beam_latch_readout();
        hv_count_t lat_h;
        hv_count_t lat_v;
        // Latch late in the line so bit 8 of h is set
        do @(negedge clk); while (beam_h < 9'd260 || beam_h > 9'd300);
        @(posedge clk);
        bus_cycle(B_SLHV, 8'h0);
        check_count("h_ctr", last_beam_h, last_h);
        check_count("v_ctr", last_beam_v, last_v);
        lat_h = last_beam_h;
        lat_v = last_beam_v;
        bus_cycle(B_STAT78, 8'h0);
        check_rdata("STAT78 after latch", 8'h40 | 8'(`PPU_VERSION));
        bus_cycle(B_OPHCT, 8'h0);
        check_rdata("OPHCT low", lat_h[7:0]);
        bus_cycle(B_OPHCT, 8'h0);
        check_rdata("OPHCT high", {7'h0, lat_h[8]});
        bus_cycle(B_OPVCT, 8'h0);
        check_rdata("OPVCT low", lat_v[7:0]);
        bus_cycle(B_OPVCT, 8'h0);
        check_rdata("OPVCT high", {7'h0, lat_v[8]});
        // Leaves the h toggle set for the status read to clear
        bus_cycle(B_OPHCT, 8'h0);
        check_rdata("OPHCT third read", lat_h[7:0]);
        bus_cycle(B_STAT78, 8'h0);
        check_rdata("STAT78 cleared", 8'(`PPU_VERSION));
        bus_cycle(B_OPHCT, 8'h0);
        check_rdata("OPHCT after status", lat_h[7:0]);
        finish_test("beam latch");
    endtask

    initial begin
        reset = 1'b1;
        cpu_en = 1'b0;
        b_op = B_NOP;
        wdata = '0;
        {errors, checks, tests, err_base} = '0;
        void'($urandom(32'h748));
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        check_reset_values();
        vram_round_trip();
        vram_step_remap();
        palette_round_trip();
        multiplier_products();
        beam_latch_readout();

        errors += i_ppu_cpu_port.i_ppu_cpu_port_checker.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim/ppu_cpu_port_checker.sv ====
// --------------------
// Bound assertions on beam counters,
// idle read data and decode strobes
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module ppu_cpu_port_checker (
    input logic                    clk,
    input logic                    reset,
    input ppu_bus_pkg::b_op_t      b_op,
    input ppu_bus_pkg::bus_byte_t  rdata,
    input ppu_mem_pkg::hv_count_t  h_ctr,
    input ppu_mem_pkg::hv_count_t  v_ctr,
    input logic vmain_wr, vaddr_lo_wr, vaddr_hi_wr, vdata_lo_wr, vdata_hi_wr,
    input logic vread_lo, vread_hi, cgadd_wr, cgdata_wr, cgread,
    input logic m7a_wr, m7b_wr, hv_latch, hct_read, vct_read, stat_read
);
    import ppu_bus_pkg::*;

    localparam int H_LAST = `PPU_H_DOTS - 1;

    int fail_count = 0;

    h_ctr_in_range: assert property (@(posedge clk) disable iff (reset)
        h_ctr <= H_LAST)
        else begin
            $error("h_ctr went past the last dot of the line");
            fail_count++;
        end

    // Line count moves only on the last dot
    v_ctr_on_wrap: assert property (@(posedge clk) disable iff (reset)
        (v_ctr != $past(v_ctr)) |-> ($past(h_ctr) == H_LAST))
        else begin
            $error("v_ctr changed without an h_ctr wrap");
            fail_count++;
        end

    nop_reads_zero: assert property (@(posedge clk) disable iff (reset)
        (b_op == B_NOP) |-> (rdata == '0))
        else begin
            $error("rdata is not zero for a NOP");
            fail_count++;
        end

    strobes_onehot0: assert property (@(posedge clk) disable iff (reset)
        $onehot0({vmain_wr, vaddr_lo_wr, vaddr_hi_wr, vdata_lo_wr, vdata_hi_wr,
                  vread_lo, vread_hi, cgadd_wr, cgdata_wr, cgread,
                  m7a_wr, m7b_wr, hv_latch, hct_read, vct_read, stat_read}))
        else begin
            $error("more than one decode strobe is active");
            fail_count++;
        end

endmodule

bind ppu_cpu_port ppu_cpu_port_checker i_ppu_cpu_port_checker (.*);

// ==== source/ppu_cpu_port.sv ====
// --------------------
// PPU CPU register port, top level
// --------------------

`timescale 1ns/1ps

module ppu_cpu_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cpu_en,
    input  ppu_bus_pkg::b_op_t      b_op,
    input  ppu_bus_pkg::bus_byte_t  wdata,
    output ppu_bus_pkg::bus_byte_t  rdata,
    output ppu_mem_pkg::hv_count_t  h_ctr,
    output ppu_mem_pkg::hv_count_t  v_ctr
);
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    // Decode strobes
    logic vmain_wr, vaddr_lo_wr, vaddr_hi_wr, vdata_lo_wr, vdata_hi_wr;
    logic vread_lo, vread_hi;
    logic cgadd_wr, cgdata_wr, cgread;
    logic m7a_wr, m7b_wr;
    logic hv_latch, hct_read, vct_read, stat_read;

    // Read values
    vram_word_t  prefetch;
    bus_byte_t   cg_byte;
    mul_result_t product;
    bus_byte_t   hct_byte, vct_byte, stat_byte;

    ppu_reg_decode i_ppu_reg_decode (
        .cpu_en, .b_op,
        .vmain_wr, .vaddr_lo_wr, .vaddr_hi_wr, .vdata_lo_wr, .vdata_hi_wr,
        .vread_lo, .vread_hi, .cgadd_wr, .cgdata_wr, .cgread,
        .m7a_wr, .m7b_wr, .hv_latch, .hct_read, .vct_read, .stat_read
    );

    vram_port i_vram_port (
        .clk, .reset, .vmain_wr, .vaddr_lo_wr, .vaddr_hi_wr,
        .vdata_lo_wr, .vdata_hi_wr, .vread_lo, .vread_hi, .wdata, .prefetch
    );

    cgram_port i_cgram_port (
        .clk, .reset, .cgadd_wr, .cgdata_wr, .cgread, .wdata, .cg_byte
    );

    m7_multiplier i_m7_multiplier (
        .clk, .reset, .m7a_wr, .m7b_wr, .wdata, .product
    );

    hv_counter_latch i_hv_counter_latch (
        .clk, .reset, .hv_latch, .hct_read, .vct_read, .stat_read,
        .h_ctr, .v_ctr, .hct_byte, .vct_byte, .stat_byte
    );

    read_mux i_read_mux (
        .b_op, .prefetch, .cg_byte, .product,
        .hct_byte, .vct_byte, .stat_byte, .rdata
    );

endmodule

// ==== source/read_mux.sv ====
// --------------------
// Read-data selector for the register bus
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module read_mux (
    input  ppu_bus_pkg::b_op_t        b_op,
    input  ppu_mem_pkg::vram_word_t   prefetch,
    input  ppu_bus_pkg::bus_byte_t    cg_byte,
    input  ppu_mem_pkg::mul_result_t  product,
    input  ppu_bus_pkg::bus_byte_t    hct_byte,
    input  ppu_bus_pkg::bus_byte_t    vct_byte,
    input  ppu_bus_pkg::bus_byte_t    stat_byte,
    output ppu_bus_pkg::bus_byte_t    rdata
);
    import ppu_bus_pkg::*;

    // Values are sampled before the read's own side effects land
    always_comb begin
        case (b_op)
            B_RDVRAML: rdata = prefetch[7:0];
            B_RDVRAMH: rdata = prefetch[15:8];
            B_RDCGRAM: rdata = cg_byte;
            B_MPYL:    rdata = product[7:0];
            B_MPYM:    rdata = product[15:8];
            B_MPYH:    rdata = product[23:16];
            B_OPHCT:   rdata = hct_byte;
            B_OPVCT:   rdata = vct_byte;
            B_STAT78:  rdata = stat_byte;
            default:   rdata = 8'h0;
        endcase
    end

endmodule

// ==== source/hv_counter_latch.sv ====
// --------------------
// Beam counters, software latch,
// two-byte readout and status byte
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module hv_counter_latch (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hv_latch,
    input  logic                    hct_read,
    input  logic                    vct_read,
    input  logic                    stat_read,
    output ppu_mem_pkg::hv_count_t  h_ctr,
    output ppu_mem_pkg::hv_count_t  v_ctr,
    output ppu_bus_pkg::bus_byte_t  hct_byte,
    output ppu_bus_pkg::bus_byte_t  vct_byte,
    output ppu_bus_pkg::bus_byte_t  stat_byte
);
    import ppu_mem_pkg::*;

    hv_count_t h_lat;
    hv_count_t v_lat;
    logic      latch_flag;
    logic      h_tgl;
    logic      v_tgl;
    logic      h_wrap;
    logic      v_wrap;

    assign h_wrap = (h_ctr == hv_count_t'(`PPU_H_DOTS - 1));
    assign v_wrap = (v_ctr == hv_count_t'(`PPU_V_LINES - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            h_ctr <= '0;
            v_ctr <= '0;
        end else begin
            h_ctr <= h_wrap ? '0 : h_ctr + 9'd1;
            if (h_wrap) begin
                v_ctr <= v_wrap ? '0 : v_ctr + 9'd1;
            end
        end
    end

    // --------------------
    // Latch and readout state

    always_ff @(posedge clk) begin
        if (reset) begin
            h_lat <= '0;
            v_lat <= '0;
            {latch_flag, h_tgl, v_tgl} <= 3'b000;
        end else if (hv_latch) begin
            h_lat <= h_ctr;
            v_lat <= v_ctr;
            latch_flag <= 1'b1;
        end else if (hct_read) begin
            h_tgl <= ~h_tgl;
        end else if (vct_read) begin
            v_tgl <= ~v_tgl;
        end else if (stat_read) begin
            {latch_flag, h_tgl, v_tgl} <= 3'b000;
        end
    end

    // Second read of a counter returns bit 8
    assign hct_byte = h_tgl ? {7'h0, h_lat[8]} : h_lat[7:0];
    assign vct_byte = v_tgl ? {7'h0, v_lat[8]} : v_lat[7:0];
    // Field bit stays zero without interlace
    assign stat_byte = {1'b0, latch_flag, 2'b00, 4'(`PPU_VERSION)};

endmodule

// ==== source/m7_multiplier.sv ====
// --------------------
// Write-twice operands and 16x8 signed product
// --------------------

`timescale 1ns/1ps

module m7_multiplier (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      m7a_wr,
    input  logic                      m7b_wr,
    input  ppu_bus_pkg::bus_byte_t    wdata,
    output ppu_mem_pkg::mul_result_t  product
);
    import ppu_bus_pkg::*;
    import ppu_mem_pkg::*;

    m7_operand_t m7_a;
    bus_byte_t   m7_b;
    // Last byte written to either operand
    bus_byte_t   m7_old;

    always_ff @(posedge clk) begin
        if (reset) begin
            m7_a <= '0;
            m7_b <= '0;
            m7_old <= '0;
        end else if (m7a_wr) begin
            m7_a <= {wdata, m7_old};
            m7_old <= wdata;
        end else if (m7b_wr) begin
            m7_b <= wdata;
            m7_old <= wdata;
        end
    end

    // Both sides sign-extended to the 24-bit result
    assign product = $signed(m7_a) * $signed(m7_b);

endmodule

// ==== source/cgram_port.sv ====
// --------------------
// Palette RAM with byte-toggled access
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module cgram_port (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cgadd_wr,
    input  logic                    cgdata_wr,
    input  logic                    cgread,
    input  ppu_bus_pkg::bus_byte_t  wdata,
    output ppu_bus_pkg::bus_byte_t  cg_byte
);
    import ppu_mem_pkg::*;

    color_t      pal [`PPU_CGRAM_ENTRIES];
    cgram_addr_t cg_addr;
    logic        cg_hi;
    color_t      cg_color;

    // Address and toggle form one 9-bit byte position
    always_ff @(posedge clk) begin
        if (reset) begin
            {cg_addr, cg_hi} <= 9'h0;
        end else if (cgadd_wr) begin
            {cg_addr, cg_hi} <= {wdata, 1'b0};
        end else if (cgdata_wr | cgread) begin
            {cg_addr, cg_hi} <= {cg_addr, cg_hi} + 9'h1;
        end
    end

    always_ff @(posedge clk) begin
        if (cgdata_wr) begin
            if (cg_hi) begin
                pal[cg_addr][14:8] <= wdata[6:0];
            end else begin
                pal[cg_addr][7:0] <= wdata;
            end
        end
    end

    assign cg_color = pal[cg_addr];
    // High byte has no bit 15
    assign cg_byte = cg_hi ? {1'b0, cg_color[14:8]} : cg_color[7:0];

endmodule

// ==== source/vram_port.sv ====
// --------------------
// VRAM array with address register, step
// increment, address remap and read prefetch
// --------------------

`timescale 1ns/1ps
`include "ppu_settings.svh"

module vram_port (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     vmain_wr,
    input  logic                     vaddr_lo_wr,
    input  logic                     vaddr_hi_wr,
    input  logic                     vdata_lo_wr,
    input  logic                     vdata_hi_wr,
    input  logic                     vread_lo,
    input  logic                     vread_hi,
    input  ppu_bus_pkg::bus_byte_t   wdata,
    output ppu_mem_pkg::vram_word_t  prefetch
);
    import ppu_mem_pkg::*;

    vram_word_t mem [`PPU_VRAM_WORDS];

    logic       inc_on_high;
    logic [1:0] remap_mode;
    logic [1:0] step_sel;
    vram_addr_t vaddr;
    vram_addr_t vaddr_next;
    vram_addr_t vaddr_mapped;
    vram_addr_t step;
    vram_addr_t fetch_addr;
    logic       sel_read;
    logic       sel_write;
    logic       fetch_req;
    logic       fetch_pending;

    // Rotate the low 8+mode address bits left by 3
    function automatic vram_addr_t remap(input vram_addr_t a, input logic [1:0] mode);
        case (mode)
            2'd1:    remap = {a[14:9], a[5:0], a[8:6]};
            2'd2:    remap = {a[14:10], a[6:0], a[9:7]};
            2'd3:    remap = {a[14:11], a[7:0], a[10:8]};
            default: remap = a;
        endcase
    endfunction

    assign sel_read  = inc_on_high ? vread_hi : vread_lo;
    assign sel_write = inc_on_high ? vdata_hi_wr : vdata_lo_wr;
    assign fetch_req = vaddr_lo_wr | vaddr_hi_wr | sel_read | sel_write;
    assign vaddr_mapped = remap(vaddr, remap_mode);

    always_comb begin
        case (step_sel)
            2'd0:    step = 15'd1;
            2'd1:    step = 15'd32;
            default: step = 15'd128;
        endcase
    end

    always_comb begin
        vaddr_next = vaddr;
        if (vaddr_lo_wr) begin
            vaddr_next = {vaddr[14:8], wdata};
        end else if (vaddr_hi_wr) begin
            vaddr_next = {wdata[6:0], vaddr[7:0]};
        end else if (sel_read | sel_write) begin
            vaddr_next = vaddr + step;
        end
    end

    // --------------------
    // Control registers

    always_ff @(posedge clk) begin
        if (reset) begin
            {inc_on_high, remap_mode, step_sel} <= '0;
            vaddr <= '0;
            fetch_pending <= 1'b0;
            fetch_addr <= '0;
        end else begin
            if (vmain_wr) begin
                {inc_on_high, remap_mode, step_sel} <= {wdata[7], wdata[3:0]};
            end
            vaddr <= vaddr_next;
            fetch_pending <= fetch_req;
            // Selected read fetches from the address before the increment
            if (fetch_req) begin
                fetch_addr <= remap(sel_read ? vaddr : vaddr_next, remap_mode);
            end
        end
    end

    // --------------------
    // Array

    always_ff @(posedge clk) begin
        if (vdata_lo_wr) begin
            mem[vaddr_mapped][7:0] <= wdata;
        end
        if (vdata_hi_wr) begin
            mem[vaddr_mapped][15:8] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prefetch <= '0;
        end else if (fetch_pending) begin
            prefetch <= mem[fetch_addr];
        end
    end

endmodule

// ==== source/ppu_reg_decode.sv ====
// --------------------
// Register bus decoder, one strobe per effect
// --------------------

`timescale 1ns/1ps

module ppu_reg_decode (
    input  logic                cpu_en,
    input  ppu_bus_pkg::b_op_t  b_op,
    output logic                vmain_wr,
    output logic                vaddr_lo_wr,
    output logic                vaddr_hi_wr,
    output logic                vdata_lo_wr,
    output logic                vdata_hi_wr,
    output logic                vread_lo,
    output logic                vread_hi,
    output logic                cgadd_wr,
    output logic                cgdata_wr,
    output logic                cgread,
    output logic                m7a_wr,
    output logic                m7b_wr,
    output logic                hv_latch,
    output logic                hct_read,
    output logic                vct_read,
    output logic                stat_read
);
    import ppu_bus_pkg::*;

    always_comb begin
        {vmain_wr, vaddr_lo_wr, vaddr_hi_wr, vdata_lo_wr, vdata_hi_wr} = '0;
        {vread_lo, vread_hi, cgadd_wr, cgdata_wr, cgread} = '0;
        {m7a_wr, m7b_wr, hv_latch, hct_read, vct_read, stat_read} = '0;
        if (cpu_en) begin
            case (b_op)
                B_VMAIN:   vmain_wr = 1'b1;
                B_VMADDL:  vaddr_lo_wr = 1'b1;
                B_VMADDH:  vaddr_hi_wr = 1'b1;
                B_VMDATAL: vdata_lo_wr = 1'b1;
                B_VMDATAH: vdata_hi_wr = 1'b1;
                B_RDVRAML: vread_lo = 1'b1;
                B_RDVRAMH: vread_hi = 1'b1;
                B_CGADD:   cgadd_wr = 1'b1;
                B_CGDATA:  cgdata_wr = 1'b1;
                B_RDCGRAM: cgread = 1'b1;
                B_M7A:     m7a_wr = 1'b1;
                B_M7B:     m7b_wr = 1'b1;
                B_SLHV:    hv_latch = 1'b1;
                B_OPHCT:   hct_read = 1'b1;
                B_OPVCT:   vct_read = 1'b1;
                B_STAT78:  stat_read = 1'b1;
                // Product reads and NOP have no side effect
                default: ;
            endcase
        end
    end

endmodule

// ==== source/ppu_mem_pkg.sv ====
// --------------------
// Memory and datapath types
// --------------------

package ppu_mem_pkg;

    // VRAM word address and word
    typedef logic [14:0] vram_addr_t;
    typedef logic [15:0] vram_word_t;

    // Palette index and BGR555 color
    typedef logic [7:0]  cgram_addr_t;
    typedef logic [14:0] color_t;

    // Beam position
    typedef logic [8:0]  hv_count_t;

    // Multiplier operand and signed product
    typedef logic [15:0] m7_operand_t;
    typedef logic [23:0] mul_result_t;

endpackage

// ==== source/ppu_bus_pkg.sv ====
// --------------------
// Register bus types: operation codes
// and the data byte
// --------------------

package ppu_bus_pkg;

    // One code per register access on the CPU bus
    typedef enum logic [4:0] {
        B_NOP     = 5'd0,
        B_VMAIN   = 5'd1,
        B_VMADDL  = 5'd2,
        B_VMADDH  = 5'd3,
        B_VMDATAL = 5'd4,
        B_VMDATAH = 5'd5,
        B_RDVRAML = 5'd6,
        B_RDVRAMH = 5'd7,
        B_CGADD   = 5'd8,
        B_CGDATA  = 5'd9,
        B_RDCGRAM = 5'd10,
        B_M7A     = 5'd11,
        B_M7B     = 5'd12,
        B_MPYL    = 5'd13,
        B_MPYM    = 5'd14,
        B_MPYH    = 5'd15,
        B_SLHV    = 5'd16,
        B_OPHCT   = 5'd17,
        B_OPVCT   = 5'd18,
        B_STAT78  = 5'd19
    } b_op_t;

    // Write and read data on the bus
    typedef logic [7:0] bus_byte_t;

endpackage

// ==== source/ppu_settings.svh ====
// --------------------
// Frame timing, memory depths and
// the status version for the PPU CPU port
// --------------------

`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// --------------------
// Beam timing

// Dots per scanline
`define PPU_H_DOTS 341
// Scanlines per frame
`define PPU_V_LINES 262

// --------------------
// Memories

`define PPU_VRAM_WORDS 32768
`define PPU_CGRAM_ENTRIES 256

// Low nibble of STAT78
`define PPU_VERSION 2

`endif
